// File: source/backplane_pkg.sv
//**********************************************************
// Backplane controller package
// Bus and drive widths, register address map, reset values,
// LED mode encoding and blink half-periods
//**********************************************************
`default_nettype none

package backplane_pkg;

	localparam int NUM_DRIVES = 8;

	typedef logic [NUM_DRIVES-1:0]   drive_vec_t;
	typedef logic [7:0]              reg_addr_t;
	typedef logic [7:0]              reg_data_t;

	// Two bits per drive, drive n at bits 2n+1:2n
	typedef enum logic [1:0] {
		LED_OFF  = 2'b00,
		LED_ON   = 2'b01,
		LED_SLOW = 2'b10,
		LED_FAST = 2'b11
	} led_mode_t;

	typedef logic [2*NUM_DRIVES-1:0] led_mode_vec_t;

	//**********************************************************
	// Register map
	//**********************************************************
	localparam reg_addr_t ADDR_PRESENT   = 8'h00;
	localparam reg_addr_t ADDR_PG5       = 8'h01;
	localparam reg_addr_t ADDR_PG12      = 8'h02;
	localparam reg_addr_t ADDR_PWR_EN    = 8'h10;
	localparam reg_addr_t ADDR_HEALTH_LO = 8'h20;
	localparam reg_addr_t ADDR_HEALTH_HI = 8'h21;
	localparam reg_addr_t ADDR_FAULT_LO  = 8'h30;
	localparam reg_addr_t ADDR_FAULT_HI  = 8'h31;
	localparam reg_addr_t ADDR_VER_MAJ   = 8'hF0;
	localparam reg_addr_t ADDR_VER_MIN   = 8'hF1;

	// All drives powered off
	localparam drive_vec_t PWR_EN_RESET = 8'hFF;

	localparam reg_data_t VER_MAJ = 8'h01;
	localparam reg_data_t VER_MIN = 8'h03;

	// Half-periods in SYSCLK cycles
	localparam int FAST_HALF  = 4;
	localparam int SLOW_HALF  = 16;
	localparam int HEART_HALF = 64;
	localparam int TB_CNT_W   = $clog2(HEART_HALF);

endpackage

`default_nettype wire

// File: source/led_ctrl_if.sv
//**********************************************************
// LED control interface
// Mode vectors from the register block, blink phases
// from the timebase, both read by the LED driver
//**********************************************************
`timescale 1ns/10ps
`default_nettype none

interface led_ctrl_if
	import backplane_pkg::*;
();

	led_mode_vec_t health_mode;
	led_mode_vec_t fault_mode;
	logic          slow_phase;
	logic          fast_phase;

	modport regs     (output health_mode, output fault_mode);
	modport timebase (output slow_phase, output fast_phase);
	modport led      (input health_mode, input fault_mode,
	                  input slow_phase, input fast_phase);

endinterface

`default_nettype wire

// File: source/backplane_regs.sv
//**********************************************************
// Backplane register block
// Status input synchronizers, address decode, power enable
// and LED mode registers, registered read port
//**********************************************************
`timescale 1ns/10ps
`default_nettype none

module backplane_regs
	import backplane_pkg::*;
(
	input  wire             SYSCLK,
	input  wire             RESET_N,

	input  wire             wr_stb,
	input  wire             rd_stb,
	input  wire reg_addr_t  addr,
	input  wire reg_data_t  wdata,
	output reg_data_t       rdata,
	output logic            rdata_valid,

	input  wire drive_vec_t drive_present_n,
	input  wire drive_vec_t pg_5v,
	input  wire drive_vec_t pg_12v,
	output drive_vec_t      pwr_en_n,

	led_ctrl_if.regs        leds
);

	// Index 0 present, 1 is 5 V good, 2 is 12 V good
	drive_vec_t [2:0] sync_q1;
	drive_vec_t [2:0] sync_q2;

	led_mode_vec_t health_q;
	led_mode_vec_t fault_q;
	reg_data_t     rd_mux;

	//**********************************************************
	// Status synchronizers
	//**********************************************************
	always_ff @(posedge SYSCLK)
	begin
		sync_q1 <= {pg_12v, pg_5v, drive_present_n};
		sync_q2 <= sync_q1;
	end

	//**********************************************************
	// Writable registers
	//**********************************************************
	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			pwr_en_n <= PWR_EN_RESET;
			health_q <= {NUM_DRIVES{LED_OFF}};
			fault_q  <= {NUM_DRIVES{LED_OFF}};
		end
		else if (wr_stb)
		begin
			// Read-only and unmapped addresses fall through
			case (addr)
				ADDR_PWR_EN:    pwr_en_n       <= wdata;
				ADDR_HEALTH_LO: health_q[7:0]  <= wdata;
				ADDR_HEALTH_HI: health_q[15:8] <= wdata;
				ADDR_FAULT_LO:  fault_q[7:0]   <= wdata;
				ADDR_FAULT_HI:  fault_q[15:8]  <= wdata;
				default:        ;
			endcase
		end
	end

	assign leds.health_mode = health_q;
	assign leds.fault_mode  = fault_q;

	//**********************************************************
	// Read port
	//**********************************************************
	always_comb
	begin
		case (addr)
			ADDR_PRESENT:   rd_mux = sync_q2[0];
			ADDR_PG5:       rd_mux = sync_q2[1];
			ADDR_PG12:      rd_mux = sync_q2[2];
			ADDR_PWR_EN:    rd_mux = pwr_en_n;
			ADDR_HEALTH_LO: rd_mux = health_q[7:0];
			ADDR_HEALTH_HI: rd_mux = health_q[15:8];
			ADDR_FAULT_LO:  rd_mux = fault_q[7:0];
			ADDR_FAULT_HI:  rd_mux = fault_q[15:8];
			ADDR_VER_MAJ:   rd_mux = VER_MAJ;
			ADDR_VER_MIN:   rd_mux = VER_MIN;
			default:        rd_mux = '0;
		endcase
	end

	// Data captured with the strobe, valid one cycle later
	always_ff @(posedge SYSCLK)
	begin
		if (rd_stb)
			rdata <= rd_mux;
	end

	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
			rdata_valid <= 1'b0;
		else
			rdata_valid <= rd_stb;
	end

endmodule

`default_nettype wire

// File: source/blink_timebase.sv
//**********************************************************
// Blink timebase
// Free-running dividers for fast phase, slow phase and
// the heartbeat output
//**********************************************************
`timescale 1ns/10ps
`default_nettype none

module blink_timebase
	import backplane_pkg::*;
(
	input  wire           SYSCLK,
	input  wire           RESET_N,
	led_ctrl_if.timebase  leds,
	output logic          heart
);

	// 0 fast, 1 slow, 2 heartbeat
	localparam int HALF [3] = '{FAST_HALF, SLOW_HALF, HEART_HALF};

	for (genvar i = 0; i < 3; i++)
	begin : g_div
		logic [TB_CNT_W-1:0] cnt;
		logic                phase;

		always_ff @(posedge SYSCLK or negedge RESET_N)
		begin
			if (!RESET_N)
			begin
				cnt   <= '0;
				phase <= 1'b0;
			end
			else if (cnt == TB_CNT_W'(HALF[i] - 1))
			begin
				// Wrap and flip the phase
				cnt   <= '0;
				phase <= ~phase;
			end
			else
				cnt <= cnt + 1'b1;
		end
	end

	assign leds.fast_phase = g_div[0].phase;
	assign leds.slow_phase = g_div[1].phase;
	assign heart           = g_div[2].phase;

endmodule

`default_nettype wire

// File: source/led_driver.sv
//**********************************************************
// LED driver
// Per-drive mode decode for health and fault banks,
// registered LED outputs
//**********************************************************
`timescale 1ns/10ps
`default_nettype none

module led_driver
	import backplane_pkg::*;
(
	input  wire        SYSCLK,
	input  wire        RESET_N,
	led_ctrl_if.led    leds,
	output drive_vec_t health_led,
	output drive_vec_t fault_led
);

	drive_vec_t health_d;
	drive_vec_t fault_d;

	function automatic logic mode_bit(input led_mode_t mode, input logic slow,
		input logic fast);
		logic bit_val;
		case (mode)
			LED_ON:   bit_val = 1'b1;
			LED_SLOW: bit_val = slow;
			LED_FAST: bit_val = fast;
			default:  bit_val = 1'b0;
		endcase
		return bit_val;
	endfunction

	always_comb
	begin
		for (int i = 0; i < NUM_DRIVES; i++)
		begin
			health_d[i] = mode_bit(led_mode_t'(leds.health_mode[2*i +: 2]),
				leds.slow_phase, leds.fast_phase);
			fault_d[i]  = mode_bit(led_mode_t'(leds.fault_mode[2*i +: 2]),
				leds.slow_phase, leds.fast_phase);
		end
	end

	// Output flops keep the pins glitch free
	always_ff @(posedge SYSCLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			health_led <= '0;
			fault_led  <= '0;
		end
		else
		begin
			health_led <= health_d;
			fault_led  <= fault_d;
		end
	end

endmodule

`default_nettype wire

// File: source/backplane_ctrl.sv
//**********************************************************
// Backplane management controller top level
// Register block, blink timebase and LED driver joined
// through the LED control interface
//**********************************************************
`timescale 1ns/10ps
`default_nettype none

module backplane_ctrl
	import backplane_pkg::*;
(
	input  wire             SYSCLK,
	input  wire             RESET_N,

	// Register bus
	input  wire             wr_stb,
	input  wire             rd_stb,
	input  wire reg_addr_t  addr,
	input  wire reg_data_t  wdata,
	output wire reg_data_t  rdata,
	output wire             rdata_valid,

	// Board status and control
	input  wire drive_vec_t drive_present_n,
	input  wire drive_vec_t pg_5v,
	input  wire drive_vec_t pg_12v,
	output wire drive_vec_t pwr_en_n,
	output wire drive_vec_t health_led,
	output wire drive_vec_t fault_led,
	output wire             heart
);

	led_ctrl_if i_leds ();

	backplane_regs i_regs (
		.SYSCLK          (SYSCLK),
		.RESET_N         (RESET_N),
		.wr_stb          (wr_stb),
		.rd_stb          (rd_stb),
		.addr            (addr),
		.wdata           (wdata),
		.rdata           (rdata),
		.rdata_valid     (rdata_valid),
		.drive_present_n (drive_present_n),
		.pg_5v           (pg_5v),
		.pg_12v          (pg_12v),
		.pwr_en_n        (pwr_en_n),
		.leds            (i_leds.regs)
	);

	blink_timebase i_timebase (
		.SYSCLK          (SYSCLK),
		.RESET_N         (RESET_N),
		.leds            (i_leds.timebase),
		.heart           (heart)
	);

	led_driver i_led_driver (
		.SYSCLK          (SYSCLK),
		.RESET_N         (RESET_N),
		.leds            (i_leds.led),
		.health_led      (health_led),
		.fault_led       (fault_led)
	);

endmodule

`default_nettype wire

// File: bench/backplane_asserts.sv
//**********************************************************
// Bus and reset assertions for the backplane controller,
// bound to the top level
//**********************************************************
`timescale 1ns/10ps
`default_nettype none

module backplane_asserts
	import backplane_pkg::*;
(
	input wire             SYSCLK,
	input wire             RESET_N,
	input wire             wr_stb,
	input wire             rd_stb,
	input wire             rdata_valid,
	input wire drive_vec_t pwr_en_n
);

	// Valid exactly one cycle after each read strobe
	a_valid_after_read: assert property (@(posedge SYSCLK) disable iff (!RESET_N)
		rd_stb |=> rdata_valid)
		else $error("rdata_valid missing after rd_stb");

	a_valid_only_after_read: assert property (@(posedge SYSCLK) disable iff (!RESET_N)
		!rd_stb |=> !rdata_valid)
		else $error("rdata_valid without a preceding rd_stb");

	a_strobes_exclusive: assert property (@(posedge SYSCLK) disable iff (!RESET_N)
		!(wr_stb && rd_stb))
		else $error("wr_stb and rd_stb high together");

	a_power_off_at_release: assert property (@(posedge SYSCLK)
		$rose(RESET_N) |-> pwr_en_n == '1)
		else $error("pwr_en_n not all ones after reset release");

endmodule

bind backplane_ctrl backplane_asserts i_asserts (
	.SYSCLK      (SYSCLK),
	.RESET_N     (RESET_N),
	.wr_stb      (wr_stb),
	.rd_stb      (rd_stb),
	.rdata_valid (rdata_valid),
	.pwr_en_n    (pwr_en_n)
);

`default_nettype wire

// File: bench/tb_backplane.sv
//**********************************************************
// Backplane controller testbench
// Trace-driven bus stimulus, compare tasks, LED and blink
// timing checks, cycle timeout and closing status
//**********************************************************
`timescale 1ns/10ps
`default_nettype none

module tb_backplane
	import backplane_pkg::*;
();

	localparam int MAX_REC = 64;

	logic          SYSCLK;
	logic          RESET_N;
	logic          wr_stb;
	logic          rd_stb;
	reg_addr_t     addr;
	reg_data_t     wdata;
	reg_data_t     rdata;
	logic          rdata_valid;
	drive_vec_t    drive_present_n;
	drive_vec_t    pg_5v;
	drive_vec_t    pg_12v;
	drive_vec_t    pwr_en_n;
	drive_vec_t    health_led;
	drive_vec_t    fault_led;
	logic          heart;

	// Five hex bytes per record
	logic [7:0]    trace [5*MAX_REC];
	int unsigned   errors_value = 0;
	int unsigned   errors_other = 0;
	int unsigned   cycles = 0;
	int unsigned   limit = 0;
	int unsigned   num_rec;
	logic [31:0]   lcg_state;
	drive_vec_t    pwr_exp;
	led_mode_vec_t health_exp;
	led_mode_vec_t fault_exp;

	backplane_ctrl i_dut (.*);

	initial
	begin
		SYSCLK = 1'b0;
		forever #50 SYSCLK = ~SYSCLK;
	end

	initial
	begin
		wait (limit != 0);
		while (cycles < limit)
		begin
			@(posedge SYSCLK);
			cycles++;
		end
		$display("Timeout, run did not finish within %0d cycles", limit);
		$display("STATUS: FAIL");
		$finish;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Lit only for LED_ON with two mode bits per drive
	function automatic drive_vec_t led_pattern(input led_mode_vec_t modes);
		drive_vec_t pat;
		for (int i = 0; i < NUM_DRIVES; i++)
			pat[i] = (modes[2*i +: 2] == LED_ON);
		return pat;
	endfunction

	function automatic logic led_bit_at(input int sel);
		case (sel)
			0:       return health_led[0];
			1:       return health_led[1];
			default: return heart;
		endcase
	endfunction

	task automatic check_data(input string name, input reg_data_t exp, input reg_data_t act);
		if (act !== exp)
		begin
			errors_value++;
			$display("FAIL %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_drive(input string name, input drive_vec_t exp, input drive_vec_t act);
		if (act !== exp)
		begin
			errors_value++;
			$display("FAIL %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_level(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			errors_value++;
			$display("FAIL %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_gap(input string name, input int exp, input int act);
		if (act != exp)
		begin
			errors_value++;
			$display("FAIL %s edge spacing expected %h actual %h", name, exp, act);
		end
	endtask

	//**********************************************************
	// Bus and timing tasks ending 5 ns after a rising edge
	//**********************************************************
	task automatic step_cycle();
		@(posedge SYSCLK);
		#5;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) step_cycle();
	endtask

	task automatic set_status(input drive_vec_t p, input drive_vec_t g5, input drive_vec_t g12);
		drive_present_n = p;
		pg_5v           = g5;
		pg_12v          = g12;
		idle_cycles(4);
	endtask

	task automatic bus_write(input reg_addr_t a, input reg_data_t d);
		addr   = a;
		wdata  = d;
		wr_stb = 1'b1;
		step_cycle();
		wr_stb = 1'b0;
		case (a)
			ADDR_PWR_EN:    pwr_exp          = d;
			ADDR_HEALTH_LO: health_exp[7:0]  = d;
			ADDR_HEALTH_HI: health_exp[15:8] = d;
			ADDR_FAULT_LO:  fault_exp[7:0]   = d;
			ADDR_FAULT_HI:  fault_exp[15:8]  = d;
			default:        ;
		endcase
		check_drive("pwr_en_n", pwr_exp, pwr_en_n);
	endtask

	task automatic bus_read(input reg_addr_t a, input reg_data_t exp);
		addr   = a;
		rd_stb = 1'b1;
		step_cycle();
		rd_stb = 1'b0;
		if (rdata_valid !== 1'b1)
		begin
			errors_other++;
			$display("No rdata_valid in the cycle after the read of address %h", a);
		end
		else
			check_data("rdata", exp, rdata);
	endtask

	task automatic check_leds();
		idle_cycles(2);
		check_drive("health_led", led_pattern(health_exp), health_led);
		check_drive("fault_led", led_pattern(fault_exp), fault_led);
	endtask

	// Spacing between successive edges whatever the phase
	task automatic measure_spacing(input string name, input int sel, input int half);
		logic prev;
		int   gap;
		int   edges;
		prev  = led_bit_at(sel);
		gap   = 0;
		edges = 0;
		while (edges < 3)
		begin
			step_cycle();
			gap++;
			if (led_bit_at(sel) !== prev)
			begin
				if (edges > 0)
					check_gap(name, half, gap);
				prev = led_bit_at(sel);
				gap  = 0;
				edges++;
			end
		end
	endtask

	//**********************************************************
	// Main sequence
	//**********************************************************
	initial
	begin
		logic [7:0] op;
		RESET_N         = 1'b0;
		wr_stb          = 1'b0;
		rd_stb          = 1'b0;
		addr            = '0;
		wdata           = '0;
		drive_present_n = '1;
		pg_5v           = '0;
		pg_12v          = '0;
		lcg_state       = 32'hc159;
		pwr_exp         = '1;
		health_exp      = '0;
		fault_exp       = '0;
		for (int i = 0; i < 5*MAX_REC; i++)
			trace[i] = 8'h00;
		$readmemh("bench/backplane_trace.txt", trace);
		num_rec = 0;
		while (num_rec < MAX_REC && trace[5*num_rec] != 8'h00)
			num_rec++;
		limit = num_rec * 10 + 600;

		repeat (4) @(posedge SYSCLK);
		#5 RESET_N = 1'b1;
		check_drive("pwr_en_n", '1, pwr_en_n);
		check_level("heart", 1'b0, heart);
		check_level("rdata_valid", 1'b0, rdata_valid);

		for (int r = 0; r < num_rec; r++)
		begin
			op = trace[5*r];
			case (op)
				8'h01: set_status(trace[5*r+2], trace[5*r+3], trace[5*r+4]);
				8'h02: bus_write(trace[5*r+1], trace[5*r+2]);
				8'h03: bus_read(trace[5*r+1], trace[5*r+2]);
				8'h04: check_leds();
				8'h05:
				begin
					measure_spacing("health_led[0]", 0, FAST_HALF);
					measure_spacing("health_led[1]", 1, SLOW_HALF);
					measure_spacing("heart", 2, HEART_HALF);
				end
				default:
				begin
					errors_other++;
					$display("Unknown trace operation %h in record %0d", op, r);
				end
			endcase
			lcg_state = lcg_next(lcg_state);
			idle_cycles(int'(lcg_state[17:16]));
		end

		$display("Errors: %0d wrong values, %0d other", errors_value, errors_other);
		if (errors_value == 0 && errors_other == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: bench/backplane_trace.txt
// Columns, all hex bytes: op addr d0 d1 d2
// op 01 status (d0 present_n, d1 pg_5v, d2 pg_12v), 02 write d0, 03 read expects d0,
// op 04 static LED check, 05 blink timing, 00 ends the trace
03 f0 01 00 00
03 f1 03 00 00
03 10 ff 00 00
04 00 00 00 00
03 55 00 00 00
03 20 00 00 00
01 00 a5 3c c3
03 00 a5 00 00
03 01 3c 00 00
03 02 c3 00 00
01 00 5a f0 0f
03 00 5a 00 00
03 01 f0 00 00
03 02 0f 00 00
02 10 e7 00 00
03 10 e7 00 00
02 00 11 00 00
03 00 5a 00 00
02 20 45 00 00
02 31 14 00 00
04 00 00 00 00
03 20 45 00 00
03 31 14 00 00
// drive 0 fast, drive 1 slow
02 20 0b 00 00
05 00 00 00 00
00 00 00 00 00

// File: project.f
source/backplane_pkg.sv
source/led_ctrl_if.sv
source/backplane_regs.sv
source/blink_timebase.sv
source/led_driver.sv
source/backplane_ctrl.sv
bench/backplane_asserts.sv
bench/tb_backplane.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the backplane controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module tb_backplane \
	-Mdir "$BUILD_DIR" -o sim_backplane
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/sim_backplane" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
	exit 1
fi
exit 0
